// ==== hw/bus_arbiter.sv ====
// round-robin arbiter for two bus masters, locked per transaction
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic      clk,
	input  logic      rst,
	mem_bus_if.slave  m_fetch,
	mem_bus_if.slave  m_ls,
	mem_bus_if.master s_mem
);

	// owner and last_ls: 0 is fetch, 1 is load/store
	logic locked;
	logic owner;
	logic last_ls;

	logic pick_ls;
	logic sel_ls;
	logic any_req;
	logic resp_fire;

	assign any_req = m_fetch.req_valid || m_ls.req_valid;

	// on a tie the loser of the previous round goes first
	assign pick_ls = m_ls.req_valid && (!m_fetch.req_valid || !last_ls);
	assign sel_ls  = locked ? owner : pick_ls;

	assign resp_fire = s_mem.resp_valid && s_mem.resp_ready;

	// request path, granted combinationally while the bus is free
	assign s_mem.req_valid = sel_ls ? m_ls.req_valid : m_fetch.req_valid;
	assign s_mem.req_addr  = sel_ls ? m_ls.req_addr  : m_fetch.req_addr;
	assign s_mem.req_we    = sel_ls ? m_ls.req_we    : m_fetch.req_we;
	assign s_mem.req_wdata = sel_ls ? m_ls.req_wdata : m_fetch.req_wdata;

	assign m_fetch.req_ready = !sel_ls && s_mem.req_ready;
	assign m_ls.req_ready    = sel_ls && s_mem.req_ready;

	// response path only toward the locked owner
	assign s_mem.resp_ready = locked && (owner ? m_ls.resp_ready : m_fetch.resp_ready);

	assign m_fetch.resp_valid = locked && !owner && s_mem.resp_valid;
	assign m_ls.resp_valid    = locked && owner && s_mem.resp_valid;

	// payload is shared, qualified by resp_valid
	assign m_fetch.resp_rdata = s_mem.resp_rdata;
	assign m_fetch.resp_code  = s_mem.resp_code;
	assign m_ls.resp_rdata    = s_mem.resp_rdata;
	assign m_ls.resp_code     = s_mem.resp_code;

	always_ff @(posedge clk) begin
		if (rst) begin
			locked  <= 1'b0;
			owner   <= 1'b0;
			last_ls <= 1'b0;
		end else if (!locked) begin
			// lock on the grant cycle so the sram sees a stable request
			if (any_req) begin
				locked  <= 1'b1;
				owner   <= pick_ls;
				last_ls <= pick_ls;
			end
		end else if (resp_fire) begin
			locked <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_consts.svh ====
// reset pc, sram base address, sram depth and sram latency base
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// pc held until the first redirect
`define RESET_PC 32'h8000_0000

// first byte address decoded by the sram
`define SRAM_BASE 32'h8000_0000

// 256 words, 1 KiB
`define SRAM_WORDS_LOG2 8

// minimum response delay in cycles, addr[3:2] is added on top
`define SRAM_LAT_BASE 1

`endif

// ==== hw/fetch_pkg.sv ====
// word, address and response code types, fetch and load/store state enums
`default_nettype none

package fetch_pkg;

	// data or instruction word
	typedef logic [31:0] word_t;

	// byte address
	typedef logic [31:0] addr_t;

	// response code, same encoding as an axi rresp
	typedef logic [1:0] bus_resp_t;

	localparam bus_resp_t RESP_OKAY = 2'd0;
	localparam bus_resp_t RESP_ERR  = 2'd2;

	// fetch FSM
	typedef enum logic [1:0] {
		FS_IDLE,
		FS_ISSUE,
		FS_WAIT_RESP,
		FS_HOLD
	} fetch_state_t;

	// load/store FSM
	typedef enum logic [1:0] {
		LS_IDLE,
		LS_ISSUE,
		LS_WAIT_RESP
	} lsu_state_t;

endpackage

`default_nettype wire

// ==== hw/fetch_top.sv ====
// top level with fetch unit, load/store unit, arbiter and sram
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  redirect,
	input  addr_t redirect_pc,
	input  logic  fetch_hold,
	input  logic  ls_req,
	input  logic  ls_we,
	input  addr_t ls_addr,
	input  word_t ls_wdata,
	output logic  inst_valid,
	output addr_t inst_pc,
	output word_t inst_word,
	output logic  inst_err,
	output logic  ls_done,
	output word_t ls_rdata,
	output logic  ls_err,
	output logic  ls_busy
);

	mem_bus_if if_bus ();
	mem_bus_if ls_bus ();
	mem_bus_if mem_bus ();

	fetch_unit i_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_hold  (fetch_hold),
		.bus         (if_bus.master),
		.inst_valid  (inst_valid),
		.inst_pc     (inst_pc),
		.inst_word   (inst_word),
		.inst_err    (inst_err)
	);

	load_store_unit i_load_store_unit (
		.clk      (clk),
		.rst      (rst),
		.ls_req   (ls_req),
		.ls_we    (ls_we),
		.ls_addr  (ls_addr),
		.ls_wdata (ls_wdata),
		.bus      (ls_bus.master),
		.ls_done  (ls_done),
		.ls_err   (ls_err),
		.ls_busy  (ls_busy),
		.ls_rdata (ls_rdata)
	);

	bus_arbiter i_bus_arbiter (
		.clk     (clk),
		.rst     (rst),
		.m_fetch (if_bus.slave),
		.m_ls    (ls_bus.slave),
		.s_mem   (mem_bus.master)
	);

	inst_data_sram i_inst_data_sram (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.slave)
	);

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
// fetch unit with pc register, redirect capture and read FSM
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       redirect,
	input  addr_t      redirect_pc,
	input  logic       fetch_hold,
	mem_bus_if.master  bus,
	output logic       inst_valid,
	output addr_t      inst_pc,
	output word_t      inst_word,
	output logic       inst_err
);

	fetch_state_t state;
	addr_t        pc;
	logic         redir_pend;
	addr_t        pend_pc;

	logic  req_fire;
	logic  resp_fire;
	logic  stale;
	addr_t next_pc;

	// read-only master, request held stable from the pc register
	assign bus.req_valid  = (state == FS_ISSUE);
	assign bus.req_addr   = pc;
	assign bus.req_we     = 1'b0;
	assign bus.req_wdata  = '0;
	assign bus.resp_ready = (state == FS_WAIT_RESP);

	assign req_fire  = bus.req_valid && bus.req_ready;
	assign resp_fire = bus.resp_valid && bus.resp_ready;

	// a redirect seen any time after issue makes the outstanding word stale
	assign stale = redir_pend || redirect;

	always_comb begin
		if (redirect)
			next_pc = redirect_pc;
		else if (redir_pend)
			next_pc = pend_pc;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= FS_IDLE;
			pc         <= `RESET_PC;
			redir_pend <= 1'b0;
			inst_valid <= 1'b0;
			inst_err   <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				FS_IDLE: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= fetch_hold ? FS_HOLD : FS_ISSUE;
					end
				end
				FS_ISSUE: begin
					// payload must stay stable, so keep the target for later
					if (redirect) begin
						redir_pend <= 1'b1;
						pend_pc    <= redirect_pc;
					end
					if (req_fire)
						state <= FS_WAIT_RESP;
				end
				FS_WAIT_RESP: begin
					if (resp_fire) begin
						if (!stale) begin
							inst_valid <= 1'b1;
							inst_pc    <= pc;
							inst_word  <= bus.resp_rdata;
							inst_err   <= (bus.resp_code == RESP_ERR);
						end
						pc         <= next_pc;
						redir_pend <= 1'b0;
						state      <= fetch_hold ? FS_HOLD : FS_ISSUE;
					end else if (redirect) begin
						redir_pend <= 1'b1;
						pend_pc    <= redirect_pc;
					end
				end
				FS_HOLD: begin
					// nothing in flight here, take a redirect directly
					if (redirect)
						pc <= redirect_pc;
					if (!fetch_hold)
						state <= FS_ISSUE;
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/inst_data_sram.sv ====
// word sram with range check and address dependent response latency
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module inst_data_sram import fetch_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	mem_bus_if.slave bus
);

	localparam int DEPTH = 1 << `SRAM_WORDS_LOG2;

	word_t mem [DEPTH];

	logic       pend;
	logic       busy;
	logic [2:0] lat_cnt;
	word_t      rdata_r;
	bus_resp_t  code_r;

	addr_t                       offset;
	logic                        in_range;
	logic [`SRAM_WORDS_LOG2-1:0] idx;
	logic                        req_fire;
	logic                        resp_fire;

	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	assign offset   = bus.req_addr - `SRAM_BASE;
	assign in_range = (offset[31:`SRAM_WORDS_LOG2+2] == '0);
	assign idx      = offset[`SRAM_WORDS_LOG2+1:2];

	// accept one cycle after valid rises
	assign bus.req_ready = pend;
	assign req_fire      = bus.req_valid && pend;

	assign bus.resp_valid = busy && (lat_cnt == 3'd0);
	assign bus.resp_rdata = rdata_r;
	assign bus.resp_code  = code_r;
	assign resp_fire      = bus.resp_valid && bus.resp_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend    <= 1'b0;
			busy    <= 1'b0;
			lat_cnt <= '0;
		end else begin
			if (req_fire) begin
				pend    <= 1'b0;
				busy    <= 1'b1;
				lat_cnt <= 3'(`SRAM_LAT_BASE - 1) + 3'(bus.req_addr[3:2]);
			end else if (bus.req_valid && !busy) begin
				pend <= 1'b1;
			end
			if (busy && lat_cnt != 3'd0)
				lat_cnt <= lat_cnt - 3'd1;
			if (resp_fire)
				busy <= 1'b0;
		end
	end

	// array access at acceptance, result held until the response handshake
	always_ff @(posedge clk) begin
		if (req_fire) begin
			code_r  <= in_range ? RESP_OKAY : RESP_ERR;
			rdata_r <= (in_range && !bus.req_we) ? mem[idx] : '0;
			if (in_range && bus.req_we)
				mem[idx] <= bus.req_wdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/load_store_unit.sv ====
// load/store unit, one word access per strobe with completion strobe
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       ls_req,
	input  logic       ls_we,
	input  addr_t      ls_addr,
	input  word_t      ls_wdata,
	mem_bus_if.master  bus,
	output logic       ls_done,
	output logic       ls_err,
	output logic       ls_busy,
	output word_t      ls_rdata
);

	lsu_state_t state;
	logic       we_r;
	addr_t      addr_r;
	word_t      wdata_r;

	logic accept;
	logic req_fire;
	logic resp_fire;

	// busy stays up through the done cycle
	assign ls_busy = (state != LS_IDLE) || ls_done;
	assign accept  = ls_req && !ls_busy;

	assign bus.req_valid  = (state == LS_ISSUE);
	assign bus.req_addr   = addr_r;
	assign bus.req_we     = we_r;
	assign bus.req_wdata  = wdata_r;
	assign bus.resp_ready = (state == LS_WAIT_RESP);

	assign req_fire  = bus.req_valid && bus.req_ready;
	assign resp_fire = bus.resp_valid && bus.resp_ready;

	// captured request
	always_ff @(posedge clk) begin
		if (accept) begin
			we_r    <= ls_we;
			addr_r  <= ls_addr;
			wdata_r <= ls_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= LS_IDLE;
			ls_done <= 1'b0;
			ls_err  <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			case (state)
				LS_IDLE: begin
					if (accept)
						state <= LS_ISSUE;
				end
				LS_ISSUE: begin
					if (req_fire)
						state <= LS_WAIT_RESP;
				end
				LS_WAIT_RESP: begin
					if (resp_fire) begin
						ls_done  <= 1'b1;
						ls_err   <= (bus.resp_code == RESP_ERR);
						// stores return zero
						ls_rdata <= we_r ? '0 : bus.resp_rdata;
						state    <= LS_IDLE;
					end
				end
				default: state <= LS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
// memory bus interface with request and response channels, master and slave modports
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import fetch_pkg::*; ();

	// request channel
	logic      req_valid;
	logic      req_ready;
	addr_t     req_addr;
	logic      req_we;
	word_t     req_wdata;

	// response channel
	logic      resp_valid;
	logic      resp_ready;
	word_t     resp_rdata;
	bus_resp_t resp_code;

	// initiator side, used by both cpu-side units and by the arbiter toward the sram
	modport master (
		output req_valid, req_addr, req_we, req_wdata, resp_ready,
		input  req_ready, resp_valid, resp_rdata, resp_code
	);

	// target side, used by the sram and by the arbiter toward each unit
	modport slave (
		input  req_valid, req_addr, req_we, req_wdata, resp_ready,
		output req_ready, resp_valid, resp_rdata, resp_code
	);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the tinyfetch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim_run.log
OBJ=obj_dir

verilator --binary --timing -f tinyfetch.f --top-module fetch_tb -Mdir "$OBJ" -o fetch_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/fetch_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0

// ==== sim/fetch_tb.sv ====
// testbench for fetch_top with testdata reader, reference memory, stream monitor and timeout
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_tb;

	localparam int WORDS  = 1 << `SRAM_WORDS_LOG2;
	localparam int MARGIN = 400;

	logic        clk;
	logic        rst;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        fetch_hold;
	logic        ls_req;
	logic        ls_we;
	logic [31:0] ls_addr;
	logic [31:0] ls_wdata;
	logic        inst_valid;
	logic [31:0] inst_pc;
	logic [31:0] inst_word;
	logic        inst_err;
	logic        ls_done;
	logic [31:0] ls_rdata;
	logic        ls_err;
	logic        ls_busy;

	// reference memory, only stores change it
	logic [31:0] model [WORDS];

	string       kind_q [$];
	logic [31:0] a_q [$];
	logic [31:0] b_q [$];
	logic [31:0] c_q [$];
	logic [31:0] d_q [$];

	int          errors      = 0;
	int          checks      = 0;
	int          cycles      = 0;
	int          limit       = 1000000;
	int          strobes     = 0;
	int          redir_cycle = 0;
	int          redir_seq   = 0;
	int          seen_seq    = 0;
	logic [31:0] new_target;
	logic [31:0] exp_pc;

	fetch_top i_fetch_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic bit in_sram(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - `SRAM_BASE;
		return off < 32'(WORDS * 4);
	endfunction

	function automatic logic [`SRAM_WORDS_LOG2-1:0] word_index(input logic [31:0] addr);
		logic [31:0] off;
		off = addr - `SRAM_BASE;
		return off[`SRAM_WORDS_LOG2+1:2];
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return in_sram(addr) ? model[word_index(addr)] : 32'd0;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// one cycle strobe, the monitor resyncs on the first strobe at the target
	task automatic send_redirect(input logic [31:0] target);
		redirect    = 1'b1;
		redirect_pc = target;
		new_target  = target;
		redir_cycle = cycles;
		redir_seq++;
		@(posedge clk);
		#1;
		redirect = 1'b0;
	endtask

	task automatic run_ls(input bit we, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [31:0] exp_rdata, input bit exp_err, input string name);
		while (ls_busy) begin
			@(posedge clk);
			#1;
		end
		ls_req   = 1'b1;
		ls_we    = we;
		ls_addr  = addr;
		ls_wdata = wdata;
		@(posedge clk);
		#1;
		ls_req = 1'b0;
		check({name, " busy after request"}, 32'd1, 32'(ls_busy));
		@(negedge clk);
		while (!ls_done)
			@(negedge clk);
		check({name, " rdata"}, exp_rdata, ls_rdata);
		check({name, " err"}, 32'(exp_err), 32'(ls_err));
		check({name, " busy at done"}, 32'd1, 32'(ls_busy));
		if (we && in_sram(addr))
			model[word_index(addr)] = wdata;
		@(posedge clk);
		#1;
		check({name, " busy after done"}, 32'd0, 32'(ls_busy));
	endtask

	task automatic run_fetch(input logic [31:0] target, input int count, input int mid_at,
			input logic [31:0] mid_pc);
		int base;
		bit mid_done;
		base     = strobes;
		mid_done = 1'b0;
		send_redirect(target);
		while (strobes - base < count) begin
			if (mid_at != 0 && !mid_done && strobes - base >= mid_at) begin
				send_redirect(mid_pc);
				mid_done = 1'b1;
			end else begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic run_hold(input int hold_cycles, input string name);
		int base;
		int resume;
		fetch_hold = 1'b1;
		// count from the edge where the DUT first sees the hold
		@(posedge clk);
		base = strobes;
		repeat (hold_cycles) @(posedge clk);
		if (strobes - base > 1) begin
			$display("%s: %0d instructions delivered while fetch_hold was high",
				name, strobes - base);
			errors++;
		end
		#1;
		fetch_hold = 1'b0;
		resume = strobes;
		while (strobes == resume) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic read_tests();
		int              fd;
		int              n;
		logic [8*96-1:0] line;
		logic [8*8-1:0]  op;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     c;
		logic [31:0]     d;
		string           kind;
		fd = $fopen("sim/fetch_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/fetch_testdata.txt");
			errors++;
			return;
		end
		limit = 16 + MARGIN;
		while (!$feof(fd)) begin
			line = '0;
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
			if (n == 5 && op != "#") begin
				if (op == "store")
					kind = "store";
				else if (op == "load")
					kind = "load";
				else if (op == "fetch")
					kind = "fetch";
				else if (op == "hold")
					kind = "hold";
				else
					kind = "unknown";
				kind_q.push_back(kind);
				a_q.push_back(a);
				b_q.push_back(b);
				c_q.push_back(c);
				d_q.push_back(d);
				// operations x 4 x 8 cycles per test
				limit += 4 * 8 * ((kind == "fetch") ? int'(b) : 1);
				if (kind == "hold")
					limit += int'(a);
			end
		end
		$fclose(fd);
	endtask

	// instruction stream check, sampled mid cycle
	always @(negedge clk) begin
		if (!rst && inst_valid) begin
			if (redir_seq == 0) begin
				$display("inst_valid arrived before any redirect at pc %h", inst_pc);
				errors++;
			end else if (seen_seq != redir_seq && inst_pc != new_target) begin
				// only a strobe already registered when the redirect went out
				if (cycles != redir_cycle) begin
					$display("old stream pc %h still delivered after redirect to %h",
						inst_pc, new_target);
					errors++;
				end
			end else begin
				if (seen_seq != redir_seq) begin
					seen_seq = redir_seq;
					exp_pc   = new_target;
				end
				check("fetch pc", exp_pc, inst_pc);
				check("fetch word", expected_word(exp_pc), inst_word);
				check("fetch err", 32'(!in_sram(exp_pc)), 32'(inst_err));
				exp_pc = exp_pc + 32'd4;
				strobes++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("run timed out after %0d cycles without finishing the tests", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int    base;
		int    gap;
		string name;
		void'($urandom(54));
		rst         = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		fetch_hold  = 1'b0;
		ls_req      = 1'b0;
		ls_we       = 1'b0;
		ls_addr     = '0;
		ls_wdata    = '0;
		new_target  = '0;
		exp_pc      = '0;
		for (int i = 0; i < WORDS; i++)
			model[i] = '0;
		read_tests();
		repeat (16) @(posedge clk);
		#1;
		// outputs after the reset edges
		base = errors;
		check("reset inst_valid", 32'd0, 32'(inst_valid));
		check("reset inst_err", 32'd0, 32'(inst_err));
		check("reset ls_done", 32'd0, 32'(ls_done));
		check("reset ls_err", 32'd0, 32'(ls_err));
		check("reset ls_busy", 32'd0, 32'(ls_busy));
		$display("reset values: %s", (errors == base) ? "ok" : "mismatch");
		rst = 1'b0;
		for (int t = 0; t < kind_q.size(); t++) begin
			gap = int'($urandom % 4);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			name = $sformatf("%s %h", kind_q[t], a_q[t]);
			base = errors;
			if (kind_q[t] == "store")
				run_ls(1'b1, a_q[t], b_q[t], 32'd0, c_q[t][0], name);
			else if (kind_q[t] == "load")
				run_ls(1'b0, a_q[t], 32'd0, b_q[t], c_q[t][0], name);
			else if (kind_q[t] == "fetch")
				run_fetch(a_q[t], int'(b_q[t]), int'(c_q[t]), d_q[t]);
			else if (kind_q[t] == "hold")
				run_hold(int'(a_q[t]), name);
			else begin
				$display("test %0d has an unknown operation in the testdata", t);
				errors++;
			end
			$display("test %0d %s: %s", t, name, (errors == base) ? "ok" : "mismatch");
		end
		$display("tests %0d, checks %0d, errors %0d", kind_q.size(), checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/fetch_testdata.txt ====
# store a=addr b=wdata c=exp_err | load a=addr b=exp_rdata c=exp_err (all hex)
# fetch a=target b=count c=mid_at d=mid_target | hold a=cycles, unused columns 0
store 80000000 00000013 0 0
store 80000004 00100093 0 0
store 80000008 00200113 0 0
store 8000000c 002081b3 0 0
store 80000010 40208233 0 0
store 80000014 0000006f 0 0
store 80000040 00a00293 0 0
store 80000044 00b00313 0 0
store 80000048 006283b3 0 0
store 800003f4 fffff06f 0 0
load 80000004 00100093 0 0
load 80000044 00b00313 0 0
store 90000000 deadbeef 1 0
store 80000400 cafef00d 1 0
store 7ffffffc 12345678 1 0
load 90000000 00000000 1 0
load 80000000 00000013 0 0
load 800003fc 00000000 0 0
fetch 80000000 6 0 0
fetch 80000100 8 3 80000040
store 80000380 11111111 0 0
store 80000384 22222222 0 0
load 80000380 11111111 0 0
store 80000388 33333333 0 0
load 80000384 22222222 0 0
load 80000388 33333333 0 0
fetch 80000200 4 0 0
hold 14 0 0 0
fetch 800003f0 8 0 0
load 80000380 11111111 0 0

// ==== tinyfetch.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/mem_bus_if.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/bus_arbiter.sv
hw/inst_data_sram.sv
hw/fetch_top.sv
sim/fetch_tb.sv
